// File: common/mul_pkg.sv
// shared widths and message types for the iterative multiplier
// every user refers to these by scoped name, never by import

package mul_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------

  // operand width of one request word
  localparam int operand_width = 32;

  // full product width, twice the operand
  localparam int result_width = 64;

  // one add-shift step per multiplier bit
  localparam int step_count = 32;

  // wide enough to hold step_count minus one
  localparam int step_width = 5;

  // ----------------------------------------------------------
  // messages
  // ----------------------------------------------------------

  // request word, both operands in two's complement
  // a sits in the upper half, b in the lower half
  typedef struct packed {
    logic signed [operand_width-1:0] a;
    logic signed [operand_width-1:0] b;
  } mul_req_t;

  // response word
  typedef struct packed {
    logic [result_width-1:0] result;
  } mul_resp_t;

  // ----------------------------------------------------------
  // control from fsm to datapath
  // ----------------------------------------------------------

  // load captures magnitudes and sign, clears the partial product
  // step runs one conditional add then shift
  typedef struct packed {
    logic load;
    logic step;
  } mul_ctrl_t;

endpackage

// File: hdl/step_counter.sv
// down-counter for the add-shift sequence
// start loads the step count, step_en walks it down to the final step

module step_counter (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic step_en,
  output logic last_step
);

  logic [mul_pkg::step_width-1:0] count;

  // set between start and the final step
  logic running;

  always_ff @(posedge clk) begin
    if (reset) begin
      count   <= '0;
      running <= 1'b0;
    end else if (start) begin
      // first step counts down from here
      count   <= mul_pkg::step_width'(mul_pkg::step_count - 1);
      running <= 1'b1;
    end else if (step_en) begin
      count <= count - 1'b1;
      // the final step ends the run
      if (last_step) begin
        running <= 1'b0;
      end
    end
  end

  // only meaningful inside an operation
  assign last_step = running && (count == '0);

endmodule

// File: int_mul/mul_ctrl.sv
// control FSM for the iterative multiplier
// runs both val/rdy handshakes and steers the datapath one step per cycle

module mul_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  output logic               resp_val,
  input  logic               resp_rdy,
  input  logic               last_step,
  output logic               start,
  output logic               step_en,
  output mul_pkg::mul_ctrl_t ctrl
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_t;

  state_t state;
  state_t state_next;

  // ----------------------------------------------------------
  // state transitions
  // ----------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        // request accepted
        if (req_val) begin
          state_next = st_calc;
        end
      end
      st_calc: begin
        // step 32 happens on this same edge
        if (last_step) begin
          state_next = st_done;
        end
      end
      st_done: begin
        // hold result until the consumer takes it
        if (resp_rdy) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------------------------
  // outputs, straight from the state
  // ----------------------------------------------------------

  always_comb begin
    req_rdy  = (state == st_idle);
    resp_val = (state == st_done);

    // accepting edge loads both counter and datapath
    start   = req_rdy && req_val;
    step_en = (state == st_calc);

    ctrl.load = start;
    ctrl.step = step_en;
  end

endmodule

// File: int_mul/mul_dpath.sv
// datapath of the iterative multiplier
// multiplies operand magnitudes by add-shift, then restores the sign
// on the way out

module mul_dpath (
  input  logic                clk,
  input  logic                reset,
  input  mul_pkg::mul_req_t   req_msg,
  input  mul_pkg::mul_ctrl_t  ctrl,
  output mul_pkg::mul_resp_t  resp_msg
);

  // ----------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------

  logic [mul_pkg::operand_width-1:0] a_mag;
  logic [mul_pkg::operand_width-1:0] b_mag;
  logic                              a_neg;
  logic                              b_neg;

  assign a_neg = req_msg.a[mul_pkg::operand_width-1];
  assign b_neg = req_msg.b[mul_pkg::operand_width-1];

  // the most negative value maps to its own bit pattern
  // which is the right unsigned magnitude
  assign a_mag = a_neg ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_mag = b_neg ? (~req_msg.b + 1'b1) : req_msg.b;

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------

  // multiplicand, shifted left once per step
  logic [mul_pkg::result_width-1:0]  mcand;

  // multiplier, shifted right once per step
  logic [mul_pkg::operand_width-1:0] mplier;

  // running sum of the magnitude product
  logic [mul_pkg::result_width-1:0]  partial;

  // product is negative when exactly one operand was
  logic                              prod_neg;

  // next partial product for this step
  logic [mul_pkg::result_width-1:0]  partial_add;

  // add only when the current multiplier bit is set
  assign partial_add = mplier[0] ? (partial + mcand) : partial;

  always_ff @(posedge clk) begin
    if (reset) begin
      mcand    <= '0;
      mplier   <= '0;
      partial  <= '0;
      prod_neg <= 1'b0;
    end else if (ctrl.load) begin
      // zero-extend a into the low half
      mcand    <= {{(mul_pkg::result_width - mul_pkg::operand_width){1'b0}}, a_mag};
      mplier   <= b_mag;
      partial  <= '0;
      prod_neg <= a_neg ^ b_neg;
    end else if (ctrl.step) begin
      partial <= partial_add;
      mcand   <= mcand << 1;
      mplier  <= mplier >> 1;
    end
  end

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------

  // combinational, so resp_msg holds as long as the registers hold
  assign resp_msg.result = prod_neg ? (~partial + 1'b1) : partial;

endmodule

// File: int_mul/int_mul_iterative.sv
// top level of the iterative 32-bit signed multiplier
// one request in flight, result 32 cycles after acceptance

module int_mul_iterative (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  mul_pkg::mul_req_t  req_msg,
  output logic               resp_val,
  input  logic               resp_rdy,
  output mul_pkg::mul_resp_t resp_msg
);

  // fsm to datapath
  mul_pkg::mul_ctrl_t ctrl;

  // fsm to step counter and back
  logic start;
  logic step_en;
  logic last_step;

  // handshakes and sequencing
  mul_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .last_step (last_step),
    .start     (start),
    .step_en   (step_en),
    .ctrl      (ctrl)
  );

  // counts the 32 add-shift steps
  step_counter u_counter (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .step_en   (step_en),
    .last_step (last_step)
  );

  // operand registers, add-shift, sign fix
  mul_dpath u_dpath (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .ctrl     (ctrl),
    .resp_msg (resp_msg)
  );

endmodule

// File: test/int_mul_chk.sv
// handshake properties of the multiplier top level
// bound into every int_mul_iterative instance below

module int_mul_chk (
  input logic               clk,
  input logic               reset,
  input logic               req_rdy,
  input logic               resp_val,
  input logic               resp_rdy,
  input mul_pkg::mul_resp_t resp_msg
);

  // sticky flag per property
  logic excl_bad  = 1'b0;
  logic hold_bad  = 1'b0;
  logic reset_bad = 1'b0;
  logic any_failed;

  assign any_failed = excl_bad | hold_bad | reset_bad;

  // idle and done never overlap
  only_one_side: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else begin
      $error("req_rdy and resp_val high in the same cycle");
      excl_bad = 1'b1;
    end

  // stalled response keeps its value and stays valid
  resp_holds: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)))
    else begin
      $error("resp_msg or resp_val changed while resp_rdy was low");
      hold_bad = 1'b1;
    end

  // nothing valid comes out of reset
  quiet_after_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high in the cycle after reset");
      reset_bad = 1'b1;
    end

endmodule

bind int_mul_iterative int_mul_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .resp_msg (resp_msg)
);

// File: test/tb_clock_gen.sv
// clock and reset source for the multiplier testbench
// period 100, reset held high over the first 8 rising edges

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // free-running clock, 50 low then 50 high
  initial begin
    clk = 1'b0;
    forever begin
      #50;
      clk = ~clk;
    end
  end

  // synchronous reset, released on the 8th rising edge
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: test/tb_int_mul.sv
// testbench top for the iterative multiplier
// directed then random operands, each response checked against a reference

module tb_int_mul;

  logic               clk;
  logic               reset;
  logic               req_val;
  logic               req_rdy;
  mul_pkg::mul_req_t  req_msg;
  logic               resp_val;
  logic               resp_rdy;
  mul_pkg::mul_resp_t resp_msg;

  integer seed;
  int     cycle = 0;

  // state of the comparing process
  logic               busy     = 1'b0;
  logic               seen_val = 1'b0;
  logic               holding  = 1'b0;
  int                 accept_cycle;
  mul_pkg::mul_req_t  cur_req;
  mul_pkg::mul_resp_t exp_resp;
  mul_pkg::mul_resp_t held_msg;

  tb_clock_gen u_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  int_mul_iterative dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  // ------------------------------------------------------------
  // reference and checks
  // ------------------------------------------------------------

  // signed product, both operands sign extended to 64 bits first
  function automatic mul_pkg::mul_resp_t ref_product(
    input logic signed [mul_pkg::operand_width-1:0] a,
    input logic signed [mul_pkg::operand_width-1:0] b
  );
    mul_pkg::mul_resp_t r;
    longint             pa;
    longint             pb;
    pa = longint'(a);
    pb = longint'(b);
    r.result = pa * pb;
    return r;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_resp(input string what, input mul_pkg::mul_resp_t actual,
                            input mul_pkg::mul_resp_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("FAILED at time %0t: %s, a=%0d b=%0d expected %h got %h",
                                  $time, what, cur_req.a, cur_req.b,
                                  expected.result, actual.result));
    end
  endtask

  // edges from the accepting edge to the rise of resp_val
  task automatic check_latency(input int actual);
    if (actual != mul_pkg::step_count) begin
      stop_with_failure($sformatf(
        "FAILED at time %0t: resp_val rose %0d edges after accept, expected %0d",
        $time, actual, mul_pkg::step_count));
    end
  endtask

  task automatic compare_flag(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("FAILED at time %0t: %s is %b, expected %b",
                                  $time, what, actual, expected));
    end
  endtask

  // ------------------------------------------------------------
  // comparing process, values sampled as they were before the edge
  // ------------------------------------------------------------

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!reset) begin
      if (busy) begin
        compare_flag("req_rdy during an operation", req_rdy, 1'b0);
      end else if (resp_val) begin
        stop_with_failure("resp_val went high with no request in flight");
      end
      // first sample high, so resp_val changed on the previous edge
      if (resp_val && !seen_val) begin
        check_latency(cycle - accept_cycle - 1);
        seen_val = 1'b1;
      end
      if (holding) begin
        check_resp("result changed under back-pressure", resp_msg, held_msg);
      end
      holding  = resp_val && !resp_rdy;
      held_msg = resp_msg;
      if (resp_val && resp_rdy) begin
        check_resp("wrong product", resp_msg, exp_resp);
        busy     = 1'b0;
        seen_val = 1'b0;
      end
      if (req_val && req_rdy) begin
        cur_req      = req_msg;
        exp_resp     = ref_product(req_msg.a, req_msg.b);
        accept_cycle = cycle;
        busy         = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  // one full operation, resp_rdy held low for stall cycles of done
  task automatic send_request(input logic signed [mul_pkg::operand_width-1:0] a,
                              input logic signed [mul_pkg::operand_width-1:0] b,
                              input int stall);
    int waited;
    req_msg.a <= a;
    req_msg.b <= b;
    req_val   <= 1'b1;
    waited = 0;
    @(posedge clk);
    while (!req_rdy) begin
      waited = waited + 1;
      if (waited > 100) begin
        stop_with_failure("request was not accepted within 100 cycles");
      end
      @(posedge clk);
    end
    req_val <= 1'b0;
    if (stall == 0) begin
      resp_rdy <= 1'b1;
    end else begin
      waited = 0;
      @(posedge clk);
      while (!resp_val) begin
        waited = waited + 1;
        if (waited > 2 * mul_pkg::step_count) begin
          stop_with_failure("resp_val never went high after the request was accepted");
        end
        @(posedge clk);
      end
      repeat (stall - 1) @(posedge clk);
      resp_rdy <= 1'b1;
    end
    waited = 0;
    @(posedge clk);
    while (!(resp_val && resp_rdy)) begin
      waited = waited + 1;
      if (waited > 2 * mul_pkg::step_count + 30) begin
        stop_with_failure("the response was never taken");
      end
      @(posedge clk);
    end
    resp_rdy <= 1'b0;
  endtask

  initial begin
    int                                waited;
    int                                gap;
    int                                stall;
    logic signed [mul_pkg::operand_width-1:0] a;
    logic signed [mul_pkg::operand_width-1:0] b;
    seed     = 9660;
    req_val  = 1'b0;
    req_msg  = '0;
    resp_rdy = 1'b0;

    waited = 0;
    @(posedge clk);
    while (reset) begin
      waited = waited + 1;
      if (waited > 20) begin
        stop_with_failure("reset was never released");
      end
      @(posedge clk);
    end
    compare_flag("req_rdy after reset", req_rdy, 1'b1);
    compare_flag("resp_val after reset", resp_val, 1'b0);

    // corner operands and sign combinations, mostly back to back
    send_request(0, 12345, 0);
    send_request(-7, 0, 2);
    send_request(1, -99, 0);
    send_request(-1, 5678, 1);
    send_request(-1, -1, 0);
    send_request(32'sh80000000, -1, 0);
    send_request(32'sh80000000, 32'sh80000000, 3);
    send_request(32'sh7fffffff, 32'sh80000000, 0);
    send_request(6, 7, 0);
    send_request(-6, 7, 0);
    send_request(6, -7, 5);
    send_request(-6, -7, 0);

    repeat (200) begin
      a     = $random(seed);
      b     = $random(seed);
      stall = $unsigned($random(seed)) % 21;
      gap   = $unsigned($random(seed)) % 3;
      repeat (gap) @(posedge clk);
      send_request(a, b, stall);
    end

    @(posedge clk);
    if (!dut.u_chk.any_failed) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_with_failure("a handshake assertion failed during the run");
    end
  end

endmodule

// File: files.f
common/mul_pkg.sv
hdl/step_counter.sv
int_mul/mul_ctrl.sv
int_mul/mul_dpath.sv
int_mul/int_mul_iterative.sv
test/int_mul_chk.sv
test/tb_clock_gen.sv
test/tb_int_mul.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the multiplier testbench with Verilator, run it, scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_int_mul -f files.f

./obj_dir/Vtb_int_mul | tee sim.log

if grep -qF '** PASS **' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
